//--- run.sh
#!/bin/sh
# Builds the data cache testbench with Verilator, runs it and checks the log for the pass line.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module dcache_tb \
	-f sources.f -Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
	exit 0
fi
exit 1

//--- sources.f
src/dcache_pkg.sv
src/dcache_data_ram.sv
src/dcache_tag_ram.sv
src/dcache_ctrl.sv
src/dcache_top.sv
verif/tb_clk_gen.sv
verif/wb_mem_model.sv
verif/dcache_tb.sv

//--- src/dcache_ctrl.sv
// Cache controller FSM; looks up tags, drives both RAMs and runs the core and memory Wishbone sides.
`timescale 1ns/1ps

module dcache_ctrl #(
	parameter int DCACHE_INDEX_W = 6,
	localparam int TAG_W = $bits(dcache_pkg::addr_t) - DCACHE_INDEX_W - 2
) (
	input  logic                        clk,
	input  logic                        rst,

	input  dcache_pkg::wb_req_t         cpu_req,
	output dcache_pkg::wb_rsp_t         cpu_rsp,
	output dcache_pkg::wb_req_t         mem_req,
	input  dcache_pkg::wb_rsp_t         mem_rsp,

	output logic                        data_cs,
	output logic                        data_we,
	output dcache_pkg::sel_t            data_byte_we,
	output logic [DCACHE_INDEX_W-1:0]   data_addr,
	output dcache_pkg::word_t           data_wdata,
	input  dcache_pkg::word_t           data_rdata,

	output logic                        tag_cs,
	output logic                        tag_we,
	output logic [DCACHE_INDEX_W-1:0]   tag_addr,
	output logic [TAG_W-1:0]            tag_wdata,
	input  logic [TAG_W-1:0]            tag_rdata,
	input  logic                        tag_valid
);

	localparam int ADDR_MSB = $bits(dcache_pkg::addr_t) - 1;
	localparam int IDX_LSB  = 2;
	localparam int TAG_LSB  = DCACHE_INDEX_W + IDX_LSB;

	dcache_pkg::ctrl_state_t state;
	dcache_pkg::ctrl_state_t state_nxt;

	// the accepted core request, held until it is answered.
	dcache_pkg::addr_t addr_q;
	logic              we_q;
	dcache_pkg::sel_t  sel_q;
	dcache_pkg::word_t dat_q;

	logic              hit_q;
	dcache_pkg::word_t rsp_dat_q;

	logic                      req_valid;
	logic                      lookup_rd;
	logic                      hit;
	logic                      fill;
	logic                      merge;
	logic                      mem_active;
	logic [DCACHE_INDEX_W-1:0] index;
	logic [TAG_W-1:0]          req_tag;

	assign req_valid = cpu_req.cyc & cpu_req.stb;
	assign req_tag   = addr_q[ADDR_MSB:TAG_LSB];
	assign hit       = tag_valid && (tag_rdata == req_tag);

	always_comb begin
		state_nxt = state;
		case (state)
			dcache_pkg::IDLE: begin
				if (req_valid) begin
					state_nxt = dcache_pkg::LOOKUP;
				end
			end
			dcache_pkg::LOOKUP: begin
				if (we_q) begin
					state_nxt = dcache_pkg::MEM_WRITE;
				end else if (hit) begin
					state_nxt = dcache_pkg::RESPOND;
				end else begin
					state_nxt = dcache_pkg::MEM_READ;
				end
			end
			dcache_pkg::MEM_READ, dcache_pkg::MEM_WRITE: begin
				if (mem_rsp.ack) begin
					state_nxt = dcache_pkg::RESPOND;
				end
			end
			dcache_pkg::RESPOND: begin
				state_nxt = dcache_pkg::IDLE;
			end
			default: begin
				state_nxt = dcache_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= dcache_pkg::IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (lookup_rd) begin
			addr_q <= cpu_req.adr;
			we_q   <= cpu_req.we;
			sel_q  <= cpu_req.sel;
			dat_q  <= cpu_req.dat;
		end
		if (state == dcache_pkg::LOOKUP) begin
			hit_q <= hit;
			if (!we_q) begin
				rsp_dat_q <= data_rdata;
			end
		end
		if (fill) begin
			rsp_dat_q <= mem_rsp.dat;
		end
	end

	// both arrays are read at the edge that accepts the request.
	assign lookup_rd = (state == dcache_pkg::IDLE) && req_valid;
	assign fill      = (state == dcache_pkg::MEM_READ) && mem_rsp.ack;
	assign merge     = (state == dcache_pkg::MEM_WRITE) && mem_rsp.ack && hit_q;

	assign index = (state == dcache_pkg::IDLE) ? cpu_req.adr[TAG_LSB-1:IDX_LSB]
	                                           : addr_q[TAG_LSB-1:IDX_LSB];

	assign data_cs      = lookup_rd | fill | merge;
	assign data_we      = fill | merge;
	assign data_byte_we = fill ? '1 : sel_q;
	assign data_addr    = index;
	assign data_wdata   = fill ? mem_rsp.dat : dat_q;

	assign tag_cs    = lookup_rd | fill;
	assign tag_we    = fill;
	assign tag_addr  = index;
	assign tag_wdata = req_tag;

	assign cpu_rsp.ack = (state == dcache_pkg::RESPOND);
	assign cpu_rsp.dat = rsp_dat_q;

	// every request field is built from held registers, so it stays steady while ack is low.
	assign mem_active  = (state == dcache_pkg::MEM_READ) || (state == dcache_pkg::MEM_WRITE);
	assign mem_req.cyc = mem_active;
	assign mem_req.stb = mem_active;
	assign mem_req.we  = (state == dcache_pkg::MEM_WRITE);
	assign mem_req.adr = addr_q;
	assign mem_req.sel = we_q ? sel_q : '1;
	assign mem_req.dat = dat_q;

endmodule

//--- src/dcache_data_ram.sv
// Single-port cache data array with chip select, byte write enables and a registered read port.
`timescale 1ns/1ps

module dcache_data_ram #(
	parameter int DCACHE_INDEX_W = 6
) (
	input  logic                        clk,
	input  logic                        data_cs,
	input  logic                        data_we,
	input  dcache_pkg::sel_t            data_byte_we,
	input  logic [DCACHE_INDEX_W-1:0]   data_addr,
	input  dcache_pkg::word_t           data_wdata,
	output dcache_pkg::word_t           data_rdata
);

	localparam int DEPTH  = 1 << DCACHE_INDEX_W;
	localparam int NBYTES = $bits(dcache_pkg::sel_t);

	dcache_pkg::word_t mem [DEPTH];

	// a write touches only the enabled bytes; a read updates the output register.
	always_ff @(posedge clk) begin
		if (data_cs) begin
			if (data_we) begin
				for (int b = 0; b < NBYTES; b++) begin
					if (data_byte_we[b]) begin
						mem[data_addr][b*8 +: 8] <= data_wdata[b*8 +: 8];
					end
				end
			end else begin
				data_rdata <= mem[data_addr];
			end
		end
	end

endmodule

//--- src/dcache_pkg.sv
// Shared types for the data cache: bus words, byte selects, addresses, Wishbone structs and FSM states.
package dcache_pkg;

	// a data word on either Wishbone bus.
	typedef logic [31:0] word_t;

	// one byte select per byte of a word.
	typedef logic [3:0] sel_t;

	// byte address; bits 1:0 are ignored, then index, then tag.
	typedef logic [31:0] addr_t;

	// requester side of Wishbone classic.
	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		addr_t adr;
		sel_t  sel;
		word_t dat;
	} wb_req_t;

	// responder side of Wishbone classic.
	typedef struct packed {
		logic  ack;
		word_t dat;
	} wb_rsp_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		MEM_READ,
		MEM_WRITE,
		RESPOND
	} ctrl_state_t;

endpackage

//--- src/dcache_tag_ram.sv
// Single-port cache tag array with per-line valid flops; reset invalidates every line.
`timescale 1ns/1ps

module dcache_tag_ram #(
	parameter int DCACHE_INDEX_W = 6,
	localparam int TAG_W = $bits(dcache_pkg::addr_t) - DCACHE_INDEX_W - 2
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        tag_cs,
	input  logic                        tag_we,
	input  logic [DCACHE_INDEX_W-1:0]   tag_addr,
	input  logic [TAG_W-1:0]            tag_wdata,
	output logic [TAG_W-1:0]            tag_rdata,
	output logic                        tag_valid
);

	localparam int DEPTH = 1 << DCACHE_INDEX_W;

	logic [TAG_W-1:0] tags [DEPTH];
	logic [DEPTH-1:0] valid;

	always_ff @(posedge clk) begin
		if (tag_cs) begin
			if (tag_we) begin
				tags[tag_addr] <= tag_wdata;
			end else begin
				tag_rdata <= tags[tag_addr];
			end
		end
	end

	// the valid bit is read together with the tag so both arrive in the same cycle.
	always_ff @(posedge clk) begin
		if (rst) begin
			valid     <= '0;
			tag_valid <= 1'b0;
		end else if (tag_cs) begin
			if (tag_we) begin
				valid[tag_addr] <= 1'b1;
			end else begin
				tag_valid <= valid[tag_addr];
			end
		end
	end

endmodule

//--- src/dcache_top.sv
// Top level of the direct-mapped write-through data cache with Wishbone core and memory ports.
`timescale 1ns/1ps

module dcache_top #(
	parameter int DCACHE_INDEX_W = 6,
	localparam int TAG_W = $bits(dcache_pkg::addr_t) - DCACHE_INDEX_W - 2
) (
	input  logic                clk,
	input  logic                rst,
	input  dcache_pkg::wb_req_t cpu_req,
	output dcache_pkg::wb_rsp_t cpu_rsp,
	output dcache_pkg::wb_req_t mem_req,
	input  dcache_pkg::wb_rsp_t mem_rsp
);

	logic                      data_cs;
	logic                      data_we;
	dcache_pkg::sel_t          data_byte_we;
	logic [DCACHE_INDEX_W-1:0] data_addr;
	dcache_pkg::word_t         data_wdata;
	dcache_pkg::word_t         data_rdata;

	logic                      tag_cs;
	logic                      tag_we;
	logic [DCACHE_INDEX_W-1:0] tag_addr;
	logic [TAG_W-1:0]          tag_wdata;
	logic [TAG_W-1:0]          tag_rdata;
	logic                      tag_valid;

	dcache_ctrl #(
		.DCACHE_INDEX_W (DCACHE_INDEX_W)
	) ctrl_i (
		.clk          (clk),
		.rst          (rst),
		.cpu_req      (cpu_req),
		.cpu_rsp      (cpu_rsp),
		.mem_req      (mem_req),
		.mem_rsp      (mem_rsp),
		.data_cs      (data_cs),
		.data_we      (data_we),
		.data_byte_we (data_byte_we),
		.data_addr    (data_addr),
		.data_wdata   (data_wdata),
		.data_rdata   (data_rdata),
		.tag_cs       (tag_cs),
		.tag_we       (tag_we),
		.tag_addr     (tag_addr),
		.tag_wdata    (tag_wdata),
		.tag_rdata    (tag_rdata),
		.tag_valid    (tag_valid)
	);

	dcache_data_ram #(
		.DCACHE_INDEX_W (DCACHE_INDEX_W)
	) data_ram_i (
		.clk          (clk),
		.data_cs      (data_cs),
		.data_we      (data_we),
		.data_byte_we (data_byte_we),
		.data_addr    (data_addr),
		.data_wdata   (data_wdata),
		.data_rdata   (data_rdata)
	);

	dcache_tag_ram #(
		.DCACHE_INDEX_W (DCACHE_INDEX_W)
	) tag_ram_i (
		.clk       (clk),
		.rst       (rst),
		.tag_cs    (tag_cs),
		.tag_we    (tag_we),
		.tag_addr  (tag_addr),
		.tag_wdata (tag_wdata),
		.tag_rdata (tag_rdata),
		.tag_valid (tag_valid)
	);

endmodule

//--- verif/dcache_tb.sv
// Testbench top for the data cache; drives random core traffic and checks it against a memory model.
`timescale 1ns/1ps

module dcache_tb;

	localparam int INDEX_W = 6;
	localparam int LINES   = 1 << INDEX_W;
	localparam int N_LOOP  = 16;
	localparam int N_MIX   = 400;
	// cold reads, hit pairs, write and read pairs, write-miss triples, eviction quads, mix.
	localparam int N_REQ      = LINES + 11 * N_LOOP + N_MIX;
	localparam int MAX_CYCLES = 20 * N_REQ + 100;

	logic                clk;
	logic                rst;
	dcache_pkg::wb_req_t cpu_req;
	dcache_pkg::wb_rsp_t cpu_rsp;
	dcache_pkg::wb_req_t mem_req;
	dcache_pkg::wb_rsp_t mem_rsp;
	dcache_pkg::wb_req_t last_wr;
	int                  rd_count;
	int                  wr_count;

	int seed = 32'hc1719524;
	int cycles = 0;
	int errors = 0;
	int test_err0 = 0;
	int passed = 0;
	int failed = 0;

	// memory contents, plus the tag and valid bit that each cache line should hold.
	dcache_pkg::word_t model_mem [256];
	logic [23:0]       model_tag [LINES];
	logic              model_valid [LINES];

	tb_clk_gen clk_gen_i (.clk(clk));

	dcache_top #(.DCACHE_INDEX_W(INDEX_W)) dut_i (.*);

	wb_mem_model mem_i (.*);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run went past %0d cycles", MAX_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	function automatic dcache_pkg::word_t merge_bytes(dcache_pkg::word_t old_w,
			dcache_pkg::word_t new_w, dcache_pkg::sel_t sel);
		dcache_pkg::word_t w;
		w = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				w[b*8 +: 8] = new_w[b*8 +: 8];
			end
		end
		return w;
	endfunction

	task automatic do_access(input logic we, input logic [7:0] a, input dcache_pkg::sel_t sel,
			input dcache_pkg::word_t d);
		dcache_pkg::addr_t adr;
		logic [5:0]        idx;
		logic [23:0]       tag;
		logic              hit;
		int                rd0;
		int                wr0;
		int                waited;
		adr = {22'b0, a, 2'b00};
		idx = a[5:0];
		tag = adr[31:8];
		hit = model_valid[idx] && (model_tag[idx] == tag);
		rd0 = rd_count;
		wr0 = wr_count;
		waited = 0;
		@(posedge clk);
		cpu_req.cyc <= 1'b1;
		cpu_req.stb <= 1'b1;
		cpu_req.we  <= we;
		cpu_req.adr <= adr;
		cpu_req.sel <= sel;
		cpu_req.dat <= d;
		// ack comes from a register, so it is sampled at the falling edge.
		do begin
			@(negedge clk);
			waited++;
		end while (!cpu_rsp.ack);
		if (we) begin
			if (wr_count - wr0 != 1 || rd_count != rd0) begin
				$display("mismatch at %0t: write to %08h gave %0d memory reads and %0d writes",
					$time, adr, rd_count - rd0, wr_count - wr0);
				errors++;
			end
			if (last_wr.adr != adr || last_wr.sel != sel || last_wr.dat != d) begin
				$display("mismatch at %0t: memory write %08h/%h/%08h, expected %08h/%h/%08h",
					$time, last_wr.adr, last_wr.sel, last_wr.dat, adr, sel, d);
				errors++;
			end
			model_mem[a] = merge_bytes(model_mem[a], d, sel);
		end else begin
			if (cpu_rsp.dat != model_mem[a]) begin
				$display("mismatch at %0t: read of %08h returned %08h, expected %08h",
					$time, adr, cpu_rsp.dat, model_mem[a]);
				errors++;
			end
			if (rd_count - rd0 != (hit ? 0 : 1) || wr_count != wr0) begin
				$display("mismatch at %0t: read of %08h (hit %0b) gave %0d memory reads, %0d writes",
					$time, adr, hit, rd_count - rd0, wr_count - wr0);
				errors++;
			end
			// sampled one edge after it is driven, a hit acks one cycle after that.
			if (hit && waited != 3) begin
				$display("mismatch at %0t: read hit at %08h took %0d cycles to ack, expected 1",
					$time, adr, waited - 2);
				errors++;
			end
			model_valid[idx] = 1'b1;
			model_tag[idx]   = tag;
		end
		@(posedge clk);
		cpu_req.cyc <= 1'b0;
		cpu_req.stb <= 1'b0;
	endtask

	task automatic report_test(input string name);
		if (errors == test_err0) begin
			passed++;
			$display("test %s: ok", name);
		end else begin
			failed++;
			$display("test %s: %0d errors", name, errors - test_err0);
		end
		test_err0 = errors;
	endtask

	initial begin
		logic [7:0]        a;
		dcache_pkg::word_t d;
		dcache_pkg::sel_t  sel;
		cpu_req <= '0;
		rst     <= 1'b1;
		for (int i = 0; i < 256; i++) begin
			model_mem[i] = {4{i[7:0]}} ^ 32'ha5c3_0f96;
		end
		for (int i = 0; i < LINES; i++) begin
			model_valid[i] = 1'b0;
		end
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < LINES; i++) begin
			do_access(1'b0, 8'(i + LINES * ($random(seed) & 3)), 4'hf, '0);
		end
		report_test("cold read");

		for (int i = 0; i < N_LOOP; i++) begin
			a = 8'($random(seed));
			do_access(1'b0, a, 4'hf, '0);
			do_access(1'b0, a, 4'hf, '0);
		end
		report_test("read hit");

		for (int i = 0; i < N_LOOP; i++) begin
			a = 8'($random(seed));
			sel = 4'($random(seed));
			d = $random(seed);
			do_access(1'b1, a, sel, d);
			do_access(1'b0, a, 4'hf, '0);
		end
		report_test("write-through");

		// the line first holds the other tag, so the write misses and the read must fetch.
		for (int i = 0; i < N_LOOP; i++) begin
			a = 8'($random(seed));
			do_access(1'b0, a ^ 8'h40, 4'hf, '0);
			do_access(1'b1, a, 4'($random(seed)), $random(seed));
			do_access(1'b0, a, 4'hf, '0);
		end
		report_test("write miss");

		for (int i = 0; i < N_LOOP; i++) begin
			a = 8'($random(seed));
			repeat (2) begin
				do_access(1'b0, a, 4'hf, '0);
				do_access(1'b0, a ^ 8'h80, 4'hf, '0);
			end
		end
		report_test("eviction");

		for (int i = 0; i < N_MIX; i++) begin
			do_access(1'($random(seed)), 8'($random(seed)), 4'($random(seed)), $random(seed));
		end
		report_test("random mix");

		$display("tests passed: %0d, tests failed: %0d", passed, failed);
		if (failed == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- verif/tb_clk_gen.sv
// Testbench clock source; a free-running clock with a 100 ns period.
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

endmodule

//--- verif/wb_mem_model.sv
// Testbench Wishbone slave memory of 256 words; acks after 0 to 3 random idle cycles and counts transfers.
`timescale 1ns/1ps

module wb_mem_model (
	input  logic                clk,
	input  logic                rst,
	input  dcache_pkg::wb_req_t mem_req,
	output dcache_pkg::wb_rsp_t mem_rsp,
	output int                  rd_count,
	output int                  wr_count,
	output dcache_pkg::wb_req_t last_wr
);

	dcache_pkg::word_t mem [256];
	int                seed = 32'hc1719524;
	int                delay;
	int                wait_left;
	logic              busy = 1'b0;
	logic              ack = 1'b0;
	dcache_pkg::word_t dat = '0;
	logic [7:0]        idx;

	assign mem_rsp.ack = ack;
	assign mem_rsp.dat = dat;
	assign idx         = mem_req.adr[9:2];

	// each byte of a word holds its word address, scrambled by a constant.
	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = {4{i[7:0]}} ^ 32'ha5c3_0f96;
		end
	end

	always @(posedge clk) begin
		if (rst) begin
			busy = 1'b0;
			ack      <= 1'b0;
			rd_count <= 0;
			wr_count <= 0;
		end else begin
			ack <= 1'b0;
			// a new transfer draws its delay once; a pending one keeps counting down.
			if (mem_req.cyc && mem_req.stb && !ack) begin
				if (busy) begin
					delay = wait_left;
				end else begin
					delay = $random(seed) & 3;
				end
				busy = (delay != 0);
				wait_left = delay - 1;
				if (delay == 0) begin
					ack <= 1'b1;
					if (mem_req.we) begin
						for (int b = 0; b < 4; b++) begin
							if (mem_req.sel[b]) begin
								mem[idx][b*8 +: 8] = mem_req.dat[b*8 +: 8];
							end
						end
						wr_count <= wr_count + 1;
						last_wr  <= mem_req;
					end else begin
						dat      <= mem[idx];
						rd_count <= rd_count + 1;
					end
				end
			end
		end
	end

endmodule
